// File: project.f
source/pad_pkg.sv
source/tile_reader.sv
source/tile_buffer.sv
source/tile_writer.sv
source/pad_dma_top.sv
verification/tb_clock_gen.sv
verification/pad_dma_sva.sv
verification/tb_pad_dma.sv

// File: source/pad_dma_top.sv
/*
 * Mirror padding DMA top level
 * Reader, tile buffer and writer joined by a single tile credit
 */
`timescale 1ns/1ns

module pad_dma_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  pad_pkg::addr_t    src_addr_i,
    input  pad_pkg::addr_t    dst_addr_i,
    input  pad_pkg::width_t   width_i,
    output logic              done_o,
    output pad_pkg::ar_req_t  ar_o,
    output logic              arvalid_o,
    input  logic              arready_i,
    input  pad_pkg::r_beat_t  r_i,
    input  logic              rvalid_i,
    output logic              rready_o,
    output pad_pkg::aw_req_t  aw_o,
    output logic              awvalid_o,
    input  logic              awready_i,
    output pad_pkg::w_beat_t  w_o,
    output logic              wvalid_o,
    input  logic              wready_i
);

    pad_pkg::buf_wr_t    buf_wr;
    pad_pkg::tile_desc_t load_desc;   // Reader to buffer
    pad_pkg::tile_desc_t ready_desc;  // Buffer to writer
    pad_pkg::dma_cfg_t   cfg;
    pad_pkg::buf_idx_t   rd_row, rd_col;
    pad_pkg::word_t      rd_data;
    logic                tile_loaded;
    logic                tile_ready;
    logic                credit_return;

    tile_reader u_reader (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (start_i),
        .src_addr_i      (src_addr_i),
        .dst_addr_i      (dst_addr_i),
        .width_i         (width_i),
        .done_o          (done_o),
        .ar_o            (ar_o),
        .arvalid_o       (arvalid_o),
        .arready_i       (arready_i),
        .r_i             (r_i),
        .rvalid_i        (rvalid_i),
        .rready_o        (rready_o),
        .buf_wr_o        (buf_wr),
        .tile_loaded_o   (tile_loaded),
        .tile_desc_o     (load_desc),
        .cfg_o           (cfg),
        .credit_return_i (credit_return)
    );

    tile_buffer u_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .buf_wr_i      (buf_wr),
        .tile_loaded_i (tile_loaded),
        .tile_desc_i   (load_desc),
        .tile_ready_o  (tile_ready),
        .tile_desc_o   (ready_desc),
        .rd_row_i      (rd_row),
        .rd_col_i      (rd_col),
        .rd_data_o     (rd_data)
    );

    tile_writer u_writer (
        .clk             (clk),
        .rst_n           (rst_n),
        .cfg_i           (cfg),
        .tile_ready_i    (tile_ready),
        .tile_desc_i     (ready_desc),
        .rd_row_o        (rd_row),
        .rd_col_o        (rd_col),
        .rd_data_i       (rd_data),
        .aw_o            (aw_o),
        .awvalid_o       (awvalid_o),
        .awready_i       (awready_i),
        .w_o             (w_o),
        .wvalid_o        (wvalid_o),
        .wready_i        (wready_i),
        .credit_return_o (credit_return)
    );

endmodule

// File: source/pad_pkg.sv
/*
 * Mirror padding DMA shared definitions
 * Widths, constants, FSM encodings and the bus and handshake structs
 */
package pad_pkg;

    localparam int unsigned TILE       = 4;  // Tile edge in words
    localparam int unsigned BUF_DIM    = 6;  // Tile plus one pad cell per side
    localparam int unsigned WORD_BYTES = 4;
    localparam int unsigned MIN_WIDTH  = 8;
    localparam int unsigned MAX_WIDTH  = 60;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;      // Byte address
    typedef logic [5:0]  width_t;     // Matrix width W
    typedef logic [3:0]  tile_idx_t;
    typedef logic [2:0]  buf_idx_t;

    typedef enum logic [1:0] {RD_IDLE, RD_WAIT_CREDIT, RD_RREQ, RD_RDATA} reader_state_e;
    typedef enum logic [1:0] {WR_IDLE, WR_WREQ, WR_WDATA} writer_state_e;

    typedef struct packed {
        addr_t  src;
        addr_t  dst;
        width_t width;
    } dma_cfg_t;

    typedef struct packed {
        tile_idx_t tx;
        tile_idx_t ty;
        logic      pad_top;
        logic      pad_bot;
        logic      pad_left;
        logic      pad_right;
    } tile_desc_t;

    typedef struct packed {
        addr_t addr;
    } ar_req_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } r_beat_t;

    typedef struct packed {
        addr_t      addr;
        logic [3:0] len;   // Beats minus one
    } aw_req_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } w_beat_t;

    typedef struct packed {
        logic     valid;
        buf_idx_t row;
        buf_idx_t col;
        word_t    data;
    } buf_wr_t;

endpackage

// File: source/tile_buffer.sv
/*
 * 6x6 tile buffer
 * Captures read beats into the interior and fills flagged borders by reflection
 */
`timescale 1ns/1ns

module tile_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pad_pkg::buf_wr_t     buf_wr_i,
    input  logic                 tile_loaded_i,
    input  pad_pkg::tile_desc_t  tile_desc_i,
    output logic                 tile_ready_o,
    output pad_pkg::tile_desc_t  tile_desc_o,
    input  pad_pkg::buf_idx_t    rd_row_i,
    input  pad_pkg::buf_idx_t    rd_col_i,
    output pad_pkg::word_t       rd_data_o
);

    pad_pkg::word_t mem [pad_pkg::BUF_DIM][pad_pkg::BUF_DIM];  // mem[row][col]

    // Mirror source index for one axis
    function automatic pad_pkg::buf_idx_t refl_idx(
        input int unsigned idx,
        input logic        pad_lo,
        input logic        pad_hi
    );
        if (pad_lo && idx == 0)
            return pad_pkg::buf_idx_t'(2);                     // m(-1) = 1
        if (pad_hi && idx == pad_pkg::BUF_DIM - 1)
            return pad_pkg::buf_idx_t'(pad_pkg::BUF_DIM - 3);  // m(W) = W-2
        return pad_pkg::buf_idx_t'(idx);
    endfunction

    always_ff @(posedge clk) begin
        if (buf_wr_i.valid)
            mem[buf_wr_i.row][buf_wr_i.col] <= buf_wr_i.data;
        if (tile_loaded_i) begin
            tile_desc_o <= tile_desc_i;
            // Interior cells map onto themselves, corners reflect on both axes
            for (int r = 0; r < pad_pkg::BUF_DIM; r++) begin
                for (int c = 0; c < pad_pkg::BUF_DIM; c++) begin
                    mem[r][c] <= mem[refl_idx(r, tile_desc_i.pad_top, tile_desc_i.pad_bot)]
                                    [refl_idx(c, tile_desc_i.pad_left, tile_desc_i.pad_right)];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            tile_ready_o <= 1'b0;
        else
            tile_ready_o <= tile_loaded_i;  // Padding done by then
    end

    assign rd_data_o = mem[rd_row_i][rd_col_i];

endmodule

// File: source/tile_reader.sv
/*
 * Tile reader: takes the start command, walks 4x4 tiles in raster order
 * and fetches each tile row as a 4-beat read burst into the tile buffer
 */
`timescale 1ns/1ns

module tile_reader (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  pad_pkg::addr_t       src_addr_i,
    input  pad_pkg::addr_t       dst_addr_i,
    input  pad_pkg::width_t      width_i,
    output logic                 done_o,
    output pad_pkg::ar_req_t     ar_o,
    output logic                 arvalid_o,
    input  logic                 arready_i,
    input  pad_pkg::r_beat_t     r_i,
    input  logic                 rvalid_i,
    output logic                 rready_o,
    output pad_pkg::buf_wr_t     buf_wr_o,
    output logic                 tile_loaded_o,
    output pad_pkg::tile_desc_t  tile_desc_o,
    output pad_pkg::dma_cfg_t    cfg_o,
    input  logic                 credit_return_i
);

    pad_pkg::reader_state_e state;
    pad_pkg::tile_idx_t     tx, ty;
    pad_pkg::tile_idx_t     last_tile;
    pad_pkg::tile_desc_t    cur_desc;
    pad_pkg::addr_t         src_row;
    logic [1:0]             row_cnt;     // Row within the tile
    logic [1:0]             beat_cnt;    // Beat within the row burst
    logic                   credit;      // Single tile credit
    logic                   credit_avail;
    logic                   finished;    // Last tile already loaded
    logic                   width_ok;
    logic                   row_done;

    assign width_ok = (width_i >= pad_pkg::MIN_WIDTH) && (width_i <= pad_pkg::MAX_WIDTH) &&
                      (width_i % pad_pkg::TILE == 0);
    assign last_tile    = pad_pkg::tile_idx_t'(cfg_o.width / pad_pkg::TILE - 1);
    assign credit_avail = credit || credit_return_i;  // Returned credit usable at once
    assign row_done     = (state == pad_pkg::RD_RDATA) && rvalid_i && r_i.last;

    always_comb begin
        cur_desc.tx        = tx;
        cur_desc.ty        = ty;
        cur_desc.pad_top   = (ty == 0);
        cur_desc.pad_bot   = (ty == last_tile);
        cur_desc.pad_left  = (tx == 0);
        cur_desc.pad_right = (tx == last_tile);
    end

    // Source row index is 4*ty + row
    assign src_row   = pad_pkg::addr_t'(ty) * pad_pkg::TILE + pad_pkg::addr_t'(row_cnt);
    assign ar_o.addr = cfg_o.src + (src_row * pad_pkg::addr_t'(cfg_o.width) +
                       pad_pkg::addr_t'(tx) * pad_pkg::TILE) * pad_pkg::WORD_BYTES;

    assign arvalid_o = (state == pad_pkg::RD_RREQ);
    assign rready_o  = (state == pad_pkg::RD_RDATA);
    assign done_o    = (state == pad_pkg::RD_IDLE);

    // Interior of the buffer sits at indices 1..4
    assign buf_wr_o.valid = (state == pad_pkg::RD_RDATA) && rvalid_i;
    assign buf_wr_o.row   = pad_pkg::buf_idx_t'(row_cnt) + 3'd1;
    assign buf_wr_o.col   = pad_pkg::buf_idx_t'(beat_cnt) + 3'd1;
    assign buf_wr_o.data  = r_i.data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= pad_pkg::RD_IDLE;
            credit        <= 1'b1;
            finished      <= 1'b0;
            tx            <= '0;
            ty            <= '0;
            row_cnt       <= '0;
            beat_cnt      <= '0;
            tile_loaded_o <= 1'b0;
        end else begin
            tile_loaded_o <= 1'b0;
            if (credit_return_i)
                credit <= 1'b1;
            case (state)
                pad_pkg::RD_IDLE: begin
                    if (start_i && width_ok) begin  // Bad widths are ignored
                        state    <= pad_pkg::RD_RREQ;
                        credit   <= 1'b0;
                        finished <= 1'b0;
                        tx       <= '0;
                        ty       <= '0;
                        row_cnt  <= '0;
                        beat_cnt <= '0;
                    end
                end
                pad_pkg::RD_WAIT_CREDIT: begin
                    if (credit_avail) begin
                        if (finished) begin
                            state <= pad_pkg::RD_IDLE;
                        end else begin
                            state  <= pad_pkg::RD_RREQ;
                            credit <= 1'b0;
                        end
                    end
                end
                pad_pkg::RD_RREQ: begin
                    if (arready_i)
                        state <= pad_pkg::RD_RDATA;
                end
                pad_pkg::RD_RDATA: begin
                    if (rvalid_i)
                        beat_cnt <= beat_cnt + 2'd1;
                    if (row_done) begin
                        beat_cnt <= '0;
                        row_cnt  <= row_cnt + 2'd1;  // Wraps to 0 after the fourth row
                        if (row_cnt == pad_pkg::TILE - 1) begin
                            tile_loaded_o <= 1'b1;
                            state         <= pad_pkg::RD_WAIT_CREDIT;
                            if (tx == last_tile) begin
                                tx <= '0;
                                if (ty == last_tile)
                                    finished <= 1'b1;
                                else
                                    ty <= ty + 4'd1;
                            end else begin
                                tx <= tx + 4'd1;
                            end
                        end else begin
                            state <= pad_pkg::RD_RREQ;
                        end
                    end
                end
                default: state <= pad_pkg::RD_IDLE;
            endcase
        end
    end

    // Command and tile descriptor payload
    always_ff @(posedge clk) begin
        if (state == pad_pkg::RD_IDLE && start_i && width_ok) begin
            cfg_o.src   <= src_addr_i;
            cfg_o.dst   <= dst_addr_i;
            cfg_o.width <= width_i;
        end
        if (row_done && row_cnt == pad_pkg::TILE - 1)
            tile_desc_o <= cur_desc;  // Captured before tx/ty advance
    end

endmodule

// File: source/tile_writer.sv
/*
 * Tile writer: streams the padded window of each tile as one write burst
 * per output row, then hands the tile credit back to the reader
 */
`timescale 1ns/1ns

module tile_writer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pad_pkg::dma_cfg_t    cfg_i,
    input  logic                 tile_ready_i,
    input  pad_pkg::tile_desc_t  tile_desc_i,
    output pad_pkg::buf_idx_t    rd_row_o,
    output pad_pkg::buf_idx_t    rd_col_o,
    input  pad_pkg::word_t       rd_data_i,
    output pad_pkg::aw_req_t     aw_o,
    output logic                 awvalid_o,
    input  logic                 awready_i,
    output pad_pkg::w_beat_t     w_o,
    output logic                 wvalid_o,
    input  logic                 wready_i,
    output logic                 credit_return_o
);

    pad_pkg::writer_state_e state;
    pad_pkg::buf_idx_t      row, col;
    pad_pkg::buf_idx_t      first_row, last_row;
    pad_pkg::buf_idx_t      first_col, last_col;
    pad_pkg::addr_t         dst_row, dst_col;

    // Window bounds follow the descriptor the buffer holds until the next tile
    assign first_row = tile_desc_i.pad_top   ? 3'd0 : 3'd1;
    assign last_row  = tile_desc_i.pad_bot   ? 3'd5 : 3'd4;
    assign first_col = tile_desc_i.pad_left  ? 3'd0 : 3'd1;
    assign last_col  = tile_desc_i.pad_right ? 3'd5 : 3'd4;

    assign dst_row = pad_pkg::addr_t'(tile_desc_i.ty) * pad_pkg::TILE + pad_pkg::addr_t'(row);
    assign dst_col = pad_pkg::addr_t'(tile_desc_i.tx) * pad_pkg::TILE +
                     pad_pkg::addr_t'(first_col);

    // Destination stride is W+2
    assign aw_o.addr = cfg_i.dst + (dst_row * (pad_pkg::addr_t'(cfg_i.width) + 32'd2) +
                       dst_col) * pad_pkg::WORD_BYTES;
    assign aw_o.len  = 4'(last_col - first_col);
    assign awvalid_o = (state == pad_pkg::WR_WREQ);

    assign rd_row_o = row;
    assign rd_col_o = col;
    assign w_o.data = rd_data_i;
    assign w_o.last = (col == last_col);
    assign wvalid_o = (state == pad_pkg::WR_WDATA);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= pad_pkg::WR_IDLE;
            row             <= '0;
            col             <= '0;
            credit_return_o <= 1'b0;
        end else begin
            credit_return_o <= 1'b0;
            case (state)
                pad_pkg::WR_IDLE: begin
                    if (tile_ready_i) begin
                        row   <= first_row;
                        state <= pad_pkg::WR_WREQ;
                    end
                end
                pad_pkg::WR_WREQ: begin
                    if (awready_i) begin
                        col   <= first_col;
                        state <= pad_pkg::WR_WDATA;
                    end
                end
                pad_pkg::WR_WDATA: begin
                    if (wready_i) begin
                        if (w_o.last) begin
                            if (row == last_row) begin
                                state           <= pad_pkg::WR_IDLE;
                                credit_return_o <= 1'b1;  // Tile fully written
                            end else begin
                                row   <= row + 3'd1;
                                state <= pad_pkg::WR_WREQ;
                            end
                        end else begin
                            col <= col + 3'd1;
                        end
                    end
                end
                default: state <= pad_pkg::WR_IDLE;
            endcase
        end
    end

endmodule

// File: verification/pad_dma_sva.sv
/*
 * Protocol assertions for the padding DMA AXI ports
 * Valid and payload hold, write burst length and read channel ordering
 */
`timescale 1ns/1ns

module pad_dma_sva (
    input logic              clk,
    input logic              rst_n,
    input pad_pkg::ar_req_t  ar_i,
    input logic              arvalid_i,
    input logic              arready_i,
    input logic              rready_i,
    input pad_pkg::aw_req_t  aw_i,
    input logic              awvalid_i,
    input logic              awready_i,
    input pad_pkg::w_beat_t  w_i,
    input logic              wvalid_i,
    input logic              wready_i
);

    int unsigned assert_fails = 0;
    logic [3:0]  burst_len;  // Len of the current write burst
    logic [3:0]  beat_cnt;   // Beats accepted since the AW

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            burst_len <= '0;
            beat_cnt  <= '0;
        end else if (awvalid_i && awready_i) begin
            burst_len <= aw_i.len;
            beat_cnt  <= '0;
        end else if (wvalid_i && wready_i) begin
            beat_cnt <= w_i.last ? 4'd0 : beat_cnt + 4'd1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable(ar_i))
        else begin
            assert_fails++;
            $error("AR valid or address changed before arready");
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i && !awready_i |=> awvalid_i && $stable(aw_i))
        else begin
            assert_fails++;
            $error("AW valid or payload changed before awready");
        end

    w_last_len: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i |-> (w_i.last == (beat_cnt == burst_len)))
        else begin
            assert_fails++;
            $error("W last does not match the AW burst length");
        end

    r_after_ar: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i |-> !rready_i)
        else begin
            assert_fails++;
            $error("rready high while an AR request is pending");
        end

endmodule

bind pad_dma_top pad_dma_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .ar_i      (ar_o),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .rready_i  (rready_o),
    .aw_i      (aw_o),
    .awvalid_i (awvalid_o),
    .awready_i (awready_i),
    .w_i       (w_o),
    .wvalid_i  (wvalid_o),
    .wready_i  (wready_i)
);

// File: verification/pad_golden.txt
// Per case: W src dst, then W input rows, then W+2 expected output rows (all hex)
// Input element (r,c) of case k holds k*10000 + r*100 + c
08 00001000 00002000
10000 10001 10002 10003 10004 10005 10006 10007
10100 10101 10102 10103 10104 10105 10106 10107
10200 10201 10202 10203 10204 10205 10206 10207
10300 10301 10302 10303 10304 10305 10306 10307
10400 10401 10402 10403 10404 10405 10406 10407
10500 10501 10502 10503 10504 10505 10506 10507
10600 10601 10602 10603 10604 10605 10606 10607
10700 10701 10702 10703 10704 10705 10706 10707
10101 10100 10101 10102 10103 10104 10105 10106 10107 10106
10001 10000 10001 10002 10003 10004 10005 10006 10007 10006
10101 10100 10101 10102 10103 10104 10105 10106 10107 10106
10201 10200 10201 10202 10203 10204 10205 10206 10207 10206
10301 10300 10301 10302 10303 10304 10305 10306 10307 10306
10401 10400 10401 10402 10403 10404 10405 10406 10407 10406
10501 10500 10501 10502 10503 10504 10505 10506 10507 10506
10601 10600 10601 10602 10603 10604 10605 10606 10607 10606
10701 10700 10701 10702 10703 10704 10705 10706 10707 10706
10601 10600 10601 10602 10603 10604 10605 10606 10607 10606
0C 00003000 00004000
20000 20001 20002 20003 20004 20005 20006 20007 20008 20009 2000A 2000B
20100 20101 20102 20103 20104 20105 20106 20107 20108 20109 2010A 2010B
20200 20201 20202 20203 20204 20205 20206 20207 20208 20209 2020A 2020B
20300 20301 20302 20303 20304 20305 20306 20307 20308 20309 2030A 2030B
20400 20401 20402 20403 20404 20405 20406 20407 20408 20409 2040A 2040B
20500 20501 20502 20503 20504 20505 20506 20507 20508 20509 2050A 2050B
20600 20601 20602 20603 20604 20605 20606 20607 20608 20609 2060A 2060B
20700 20701 20702 20703 20704 20705 20706 20707 20708 20709 2070A 2070B
20800 20801 20802 20803 20804 20805 20806 20807 20808 20809 2080A 2080B
20900 20901 20902 20903 20904 20905 20906 20907 20908 20909 2090A 2090B
20A00 20A01 20A02 20A03 20A04 20A05 20A06 20A07 20A08 20A09 20A0A 20A0B
20B00 20B01 20B02 20B03 20B04 20B05 20B06 20B07 20B08 20B09 20B0A 20B0B
20101 20100 20101 20102 20103 20104 20105 20106 20107 20108 20109 2010A 2010B 2010A
20001 20000 20001 20002 20003 20004 20005 20006 20007 20008 20009 2000A 2000B 2000A
20101 20100 20101 20102 20103 20104 20105 20106 20107 20108 20109 2010A 2010B 2010A
20201 20200 20201 20202 20203 20204 20205 20206 20207 20208 20209 2020A 2020B 2020A
20301 20300 20301 20302 20303 20304 20305 20306 20307 20308 20309 2030A 2030B 2030A
20401 20400 20401 20402 20403 20404 20405 20406 20407 20408 20409 2040A 2040B 2040A
20501 20500 20501 20502 20503 20504 20505 20506 20507 20508 20509 2050A 2050B 2050A
20601 20600 20601 20602 20603 20604 20605 20606 20607 20608 20609 2060A 2060B 2060A
20701 20700 20701 20702 20703 20704 20705 20706 20707 20708 20709 2070A 2070B 2070A
20801 20800 20801 20802 20803 20804 20805 20806 20807 20808 20809 2080A 2080B 2080A
20901 20900 20901 20902 20903 20904 20905 20906 20907 20908 20909 2090A 2090B 2090A
20A01 20A00 20A01 20A02 20A03 20A04 20A05 20A06 20A07 20A08 20A09 20A0A 20A0B 20A0A
20B01 20B00 20B01 20B02 20B03 20B04 20B05 20B06 20B07 20B08 20B09 20B0A 20B0B 20B0A
20A01 20A00 20A01 20A02 20A03 20A04 20A05 20A06 20A07 20A08 20A09 20A0A 20A0B 20A0A

// File: verification/tb_clock_gen.sv
/* Testbench clock and reset source, 10 ns period, reset low for 8 cycles */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;  // Released just after an edge like the other inputs
    end

endmodule

// File: verification/tb_pad_dma.sv
/*
 * Testbench for the mirror padding DMA
 * AXI memory model with random ready stalls, cases and expected matrices from the golden file
 */
`timescale 1ns/1ns

module tb_pad_dma;

    localparam int MEM_WORDS  = 8192;
    localparam int GOLD_WORDS = 510;    // W=8 case then W=12 case
    localparam int RUN_LIMIT  = 20000;  // Cycles allowed per case

    logic                clk;
    logic                rst_n;
    logic                start_i;
    pad_pkg::addr_t      src_addr_i;
    pad_pkg::addr_t      dst_addr_i;
    pad_pkg::width_t     width_i;
    logic                done_o;
    pad_pkg::ar_req_t    ar_o;
    logic                arvalid_o;
    logic                arready_i;
    pad_pkg::r_beat_t    r_i;
    logic                rvalid_i;
    logic                rready_o;
    pad_pkg::aw_req_t    aw_o;
    logic                awvalid_o;
    logic                awready_i;
    pad_pkg::w_beat_t    w_o;
    logic                wvalid_o;
    logic                wready_i;

    pad_pkg::word_t mem    [MEM_WORDS];
    pad_pkg::word_t golden [GOLD_WORDS];
    pad_pkg::addr_t rd_q   [$];     // Accepted read bursts in arrival order
    pad_pkg::addr_t dst_lo;         // Allowed write window
    pad_pkg::addr_t dst_hi;
    int             errors;
    int             ar_count;
    int             w_count;
    bit             stall_en;
    bit             aborted;        // A wait ran out of time

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pad_dma_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .src_addr_i (src_addr_i),
        .dst_addr_i (dst_addr_i),
        .width_i    (width_i),
        .done_o     (done_o),
        .ar_o       (ar_o),
        .arvalid_o  (arvalid_o),
        .arready_i  (arready_i),
        .r_i        (r_i),
        .rvalid_i   (rvalid_i),
        .rready_o   (rready_o),
        .aw_o       (aw_o),
        .awvalid_o  (awvalid_o),
        .awready_i  (awready_i),
        .w_o        (w_o),
        .wvalid_o   (wvalid_o),
        .wready_i   (wready_i)
    );

    function automatic logic pick_ready();
        if (!stall_en)
            return 1'b1;
        return ($urandom % 4) != 0;  // Stalls about one cycle in four
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("ERROR %0t: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic store_beat(input pad_pkg::addr_t addr, input pad_pkg::word_t data);
        if (addr < dst_lo || addr >= dst_hi || addr[1:0] != 2'b00) begin
            $display("ERROR %0t: write to address %h falls outside the destination matrix",
                     $time, addr);
            errors++;
        end else begin
            mem[addr >> 2] = data;
        end
    endtask

    task automatic finish_run();
        int sva_fails;
        sva_fails = uut.u_sva.assert_fails;
        $display("Summary: %0d check errors, %0d assertion failures", errors, sva_fails);
        if (errors == 0 && sva_fails == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    endtask

    // Handshakes seen at the negedge complete on the next rising edge
    initial begin : axi_mem
        logic           ar_fire, r_fire, aw_fire, w_fire;
        pad_pkg::addr_t ar_addr;
        pad_pkg::addr_t aw_addr;
        pad_pkg::addr_t wr_addr;
        pad_pkg::word_t w_data;
        int             r_beat;
        void'($urandom(2));
        arready_i = 1'b0;
        rvalid_i  = 1'b0;
        r_i       = '0;
        awready_i = 1'b0;
        wready_i  = 1'b0;
        wr_addr   = '0;
        r_beat    = 0;
        forever begin
            @(negedge clk);
            ar_fire = (arvalid_o === 1'b1) && arready_i;
            r_fire  = rvalid_i && (rready_o === 1'b1);
            aw_fire = (awvalid_o === 1'b1) && awready_i;
            w_fire  = (wvalid_o === 1'b1) && wready_i;
            ar_addr = ar_o.addr;
            aw_addr = aw_o.addr;
            w_data  = w_o.data;
            @(posedge clk);
            #1;
            if (ar_fire) begin
                rd_q.push_back(ar_addr);
                ar_count++;
            end
            if (r_fire) begin
                r_beat++;
                if (r_beat == pad_pkg::TILE) begin  // Row burst complete
                    r_beat = 0;
                    void'(rd_q.pop_front());
                end
            end
            if (aw_fire)
                wr_addr = aw_addr;
            if (w_fire) begin
                store_beat(wr_addr, w_data);
                wr_addr += pad_pkg::WORD_BYTES;
                w_count++;
            end
            if (rd_q.size() > 0) begin
                rvalid_i = 1'b1;
                r_i.data = mem[(rd_q[0] >> 2) + r_beat];
                r_i.last = (r_beat == pad_pkg::TILE - 1);
            end else begin
                rvalid_i = 1'b0;
                r_i      = '0;
            end
            arready_i = pick_ready();
            awready_i = pick_ready();
            wready_i  = pick_ready();
        end
    end

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        if (done_o !== 1'b1)
            flag_mismatch("done_o", done_o, 1);
        if (arvalid_o !== 1'b0)
            flag_mismatch("arvalid_o", arvalid_o, 0);
        if (rready_o !== 1'b0)
            flag_mismatch("rready_o", rready_o, 0);
        if (awvalid_o !== 1'b0)
            flag_mismatch("awvalid_o", awvalid_o, 0);
        if (wvalid_o !== 1'b0)
            flag_mismatch("wvalid_o", wvalid_o, 0);
    endtask

    // W=6 is outside the accepted range and must leave the engine idle
    task automatic send_bad_width();
        @(posedge clk);
        #1;
        start_i    = 1'b1;
        width_i    = 6'd6;
        src_addr_i = 32'h0000_1000;
        dst_addr_i = 32'h0000_2000;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        repeat (20) begin
            @(negedge clk);
            if (done_o !== 1'b1)
                flag_mismatch("done_o", done_o, 1);
            if (arvalid_o !== 1'b0)
                flag_mismatch("arvalid_o", arvalid_o, 0);
        end
    endtask

    task automatic run_case(inout int gi, input bit stall);
        int             w, ow, n;
        pad_pkg::addr_t src, dst;
        pad_pkg::word_t got, exp;
        w   = golden[gi];
        src = golden[gi + 1];
        dst = golden[gi + 2];
        ow  = w + 2;
        gi += 3;
        for (int i = 0; i < w * w; i++)
            mem[(src >> 2) + i] = golden[gi + i];
        gi += w * w;
        dst_lo   = dst;
        dst_hi   = dst + ow * ow * pad_pkg::WORD_BYTES;
        stall_en = stall;
        ar_count = 0;
        w_count  = 0;
        @(posedge clk);
        #1;
        start_i    = 1'b1;
        src_addr_i = src;
        dst_addr_i = dst;
        width_i    = pad_pkg::width_t'(w);
        @(posedge clk);
        #1;
        start_i = 1'b0;
        @(negedge clk);
        if (done_o !== 1'b0)
            flag_mismatch("done_o", done_o, 0);
        n = 0;
        while (done_o !== 1'b1 && n < RUN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done_o !== 1'b1) begin
            $display("Timeout: W=%0d transfer did not finish in %0d cycles", w, RUN_LIMIT);
            errors++;
            aborted = 1'b1;
        end else begin
            for (int r = 0; r < ow; r++) begin
                for (int c = 0; c < ow; c++) begin
                    got = mem[(dst >> 2) + r * ow + c];
                    exp = golden[gi + r * ow + c];
                    if (got !== exp)
                        flag_mismatch($sformatf("dst[%0d][%0d]", r, c), got, exp);
                end
            end
            if (ar_count !== w * w / pad_pkg::TILE)
                flag_mismatch("ar_count", ar_count, w * w / pad_pkg::TILE);
            if (w_count !== ow * ow)
                flag_mismatch("w_count", w_count, ow * ow);
        end
        gi += ow * ow;
    endtask

    initial begin : main
        int gi;
        errors     = 0;
        ar_count   = 0;
        w_count    = 0;
        stall_en   = 1'b0;
        aborted    = 1'b0;
        start_i    = 1'b0;
        src_addr_i = '0;
        dst_addr_i = '0;
        width_i    = '0;
        dst_lo     = '0;
        dst_hi     = '0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'hFEED_0000 | i;  // Background tagged with the word index
        $readmemh("verification/pad_golden.txt", golden);
        if ($isunknown(golden[GOLD_WORDS - 1])) begin
            $display("Golden file is missing or shorter than expected");
            errors++;
        end else begin
            wait_reset_release();
            if (!aborted) begin
                check_reset_state();
                send_bad_width();
                gi = 0;
                run_case(gi, 1'b0);  // W=8 with ready always high
                if (!aborted)
                    run_case(gi, 1'b1);  // W=12 with stalls
            end
        end
        finish_run();
    end

endmodule
